/* rtl/ex_pkg.sv */
package ex_pkg;

  localparam int XLEN         = 32;
  localparam int QUEUE_DEPTH  = 4;  // Also the upstream credit count after reset
  localparam int TAG_W        = 2;
  localparam int SINK_CREDITS = 2;
  localparam int CREDIT_W     = $clog2(SINK_CREDITS + 1);
  localparam int MUL_STAGES   = 3;

  // Major opcodes and funct7 patterns seen by the decoder
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;  // SUB and SRA
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_BRANCH,
    ALU_ZERO    // Illegal encodings land here
  } alu_op_t;

  typedef enum logic [1:0] {
    MUL_LO,
    MUL_HI_SS,
    MUL_HI_SU,
    MUL_HI_UU
  } mul_op_t;

  typedef enum logic [1:0] {
    SLOT_FREE,
    SLOT_WAIT,
    SLOT_DONE
  } slot_state_t;

endpackage

/* rtl/ex_unit.sv */
`timescale 1ns/1ps

module ex_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  logic [31:0]             instruction,
  input  logic [ex_pkg::XLEN-1:0] src_a,
  input  logic [ex_pkg::XLEN-1:0] src_b,
  input  logic                    alu_control,
  output logic                    in_credit,
  output logic                    out_valid,
  output logic [ex_pkg::XLEN-1:0] out_result,
  output logic                    out_branch_taken,
  input  logic                    out_credit
);
  import ex_pkg::*;

  logic             issue_valid;
  logic             alu_valid;
  alu_op_t          alu_op;
  logic [2:0]       alu_funct3;
  logic             mul_valid;
  mul_op_t          mul_op;
  logic [XLEN-1:0]  op_a;
  logic [XLEN-1:0]  op_b;
  logic [TAG_W-1:0] issue_tag;
  logic             alu_done;
  logic [TAG_W-1:0] alu_done_tag;
  logic [XLEN-1:0]  alu_result;
  logic             alu_branch_taken;
  logic             mul_done;
  logic [TAG_W-1:0] mul_done_tag;
  logic [XLEN-1:0]  mul_result;

  op_decode i_op_decode (
    .clk(clk), .rst(rst), .in_valid(in_valid), .instruction(instruction),
    .src_a(src_a), .src_b(src_b), .alu_control(alu_control),
    .issue_valid(issue_valid), .alu_valid(alu_valid), .alu_op(alu_op),
    .alu_funct3(alu_funct3), .mul_valid(mul_valid), .mul_op(mul_op),
    .op_a(op_a), .op_b(op_b), .issue_tag(issue_tag)
  );

  int_alu i_int_alu (
    .clk(clk), .rst(rst), .alu_valid(alu_valid), .alu_op(alu_op),
    .alu_funct3(alu_funct3), .op_a(op_a), .op_b(op_b), .alu_tag(issue_tag),
    .alu_done(alu_done), .alu_done_tag(alu_done_tag), .alu_result(alu_result),
    .alu_branch_taken(alu_branch_taken)
  );

  mul_pipe i_mul_pipe (
    .clk(clk), .rst(rst), .mul_valid(mul_valid), .mul_op(mul_op),
    .op_a(op_a), .op_b(op_b), .mul_tag(issue_tag),
    .mul_done(mul_done), .mul_done_tag(mul_done_tag), .mul_result(mul_result)
  );

  result_merge i_result_merge (
    .clk(clk), .rst(rst), .issue_valid(issue_valid),
    .alu_done(alu_done), .alu_done_tag(alu_done_tag), .alu_result(alu_result),
    .alu_branch_taken(alu_branch_taken), .mul_done(mul_done),
    .mul_done_tag(mul_done_tag), .mul_result(mul_result), .out_credit(out_credit),
    .out_valid(out_valid), .out_result(out_result),
    .out_branch_taken(out_branch_taken), .in_credit(in_credit)
  );

endmodule

/* rtl/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     alu_valid,
  input  ex_pkg::alu_op_t          alu_op,
  input  logic [2:0]               alu_funct3,
  input  logic [ex_pkg::XLEN-1:0]  op_a,
  input  logic [ex_pkg::XLEN-1:0]  op_b,
  input  logic [ex_pkg::TAG_W-1:0] alu_tag,
  output logic                     alu_done,
  output logic [ex_pkg::TAG_W-1:0] alu_done_tag,
  output logic [ex_pkg::XLEN-1:0]  alu_result,
  output logic                     alu_branch_taken
);
  import ex_pkg::*;

  logic [XLEN-1:0] diff;
  logic [XLEN-1:0] result_c;
  logic            flag_c;
  logic            lt_signed;
  logic            lt_unsigned;

  assign diff        = op_a - op_b;
  assign lt_signed   = ($signed(op_a) < $signed(op_b));
  assign lt_unsigned = (op_a < op_b);

  always_comb begin
    result_c = '0;
    flag_c   = 1'b0;
    unique case (alu_op)
      ALU_ADD:  result_c = op_a + op_b;
      ALU_SUB:  result_c = diff;
      ALU_AND:  result_c = op_a & op_b;
      ALU_OR:   result_c = op_a | op_b;
      ALU_XOR:  result_c = op_a ^ op_b;
      ALU_SLL:  result_c = op_a << op_b[4:0];
      ALU_SRL:  result_c = op_a >> op_b[4:0];
      ALU_SRA:  result_c = $signed(op_a) >>> op_b[4:0];
      ALU_SLT:  result_c = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_c = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_BRANCH: begin
        result_c = diff;
        unique case (alu_funct3)
          3'b000:  flag_c = (op_a == op_b);  // BEQ
          3'b001:  flag_c = (op_a != op_b);  // BNE
          3'b100:  flag_c = lt_signed;       // BLT
          3'b101:  flag_c = ~lt_signed;      // BGE
          3'b110:  flag_c = lt_unsigned;     // BLTU
          3'b111:  flag_c = ~lt_unsigned;    // BGEU
          default: flag_c = 1'b0;
        endcase
      end
      default:  result_c = '0;  // ALU_ZERO
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      alu_done <= 1'b0;
    end else begin
      alu_done <= alu_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (alu_valid) begin
      alu_done_tag     <= alu_tag;
      alu_result       <= result_c;
      alu_branch_taken <= flag_c;
    end
  end

endmodule

/* rtl/mul_pipe.sv */
`timescale 1ns/1ps

module mul_pipe (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     mul_valid,
  input  ex_pkg::mul_op_t          mul_op,
  input  logic [ex_pkg::XLEN-1:0]  op_a,
  input  logic [ex_pkg::XLEN-1:0]  op_b,
  input  logic [ex_pkg::TAG_W-1:0] mul_tag,
  output logic                     mul_done,
  output logic [ex_pkg::TAG_W-1:0] mul_done_tag,
  output logic [ex_pkg::XLEN-1:0]  mul_result
);
  import ex_pkg::*;

  logic [MUL_STAGES-1:0]   valid_sr;
  logic [TAG_W-1:0]        tag_sr [MUL_STAGES];
  logic                    sign_a;
  logic                    sign_b;
  logic signed [XLEN:0]    a_s1;
  logic signed [XLEN:0]    b_s1;
  logic                    hi_s1;
  logic                    hi_s2;
  logic signed [2*XLEN+1:0] prod_s2;

  // MULHU treats both operands as unsigned, MULHSU only the second
  assign sign_a = (mul_op != MUL_HI_UU);
  assign sign_b = (mul_op == MUL_LO) || (mul_op == MUL_HI_SS);

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[MUL_STAGES-2:0], mul_valid};
    end
  end

  always_ff @(posedge clk) begin
    tag_sr[0] <= mul_tag;
    for (int i = 1; i < MUL_STAGES; i++) begin
      tag_sr[i] <= tag_sr[i-1];
    end
  end

  // Stage 1 extends the operands to 33 bits
  always_ff @(posedge clk) begin
    a_s1  <= {sign_a & op_a[XLEN-1], op_a};
    b_s1  <= {sign_b & op_b[XLEN-1], op_b};
    hi_s1 <= (mul_op != MUL_LO);
  end

  // Stage 2 forms the full signed product
  always_ff @(posedge clk) begin
    prod_s2 <= a_s1 * b_s1;
    hi_s2   <= hi_s1;
  end

  // Stage 3 picks the word
  always_ff @(posedge clk) begin
    mul_result <= hi_s2 ? prod_s2[2*XLEN-1:XLEN] : prod_s2[XLEN-1:0];
  end

  assign mul_done     = valid_sr[MUL_STAGES-1];
  assign mul_done_tag = tag_sr[MUL_STAGES-1];

endmodule

/* rtl/op_decode.sv */
`timescale 1ns/1ps

module op_decode (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  logic [31:0]              instruction,
  input  logic [ex_pkg::XLEN-1:0]  src_a,
  input  logic [ex_pkg::XLEN-1:0]  src_b,
  input  logic                     alu_control,
  output logic                     issue_valid,
  output logic                     alu_valid,
  output ex_pkg::alu_op_t          alu_op,
  output logic [2:0]               alu_funct3,
  output logic                     mul_valid,
  output ex_pkg::mul_op_t          mul_op,
  output logic [ex_pkg::XLEN-1:0]  op_a,
  output logic [ex_pkg::XLEN-1:0]  op_b,
  output logic [ex_pkg::TAG_W-1:0] issue_tag
);
  import ex_pkg::*;

  logic [6:0]      opcode;
  logic [6:0]      funct7;
  logic [2:0]      funct3;
  logic [4:0]      shamt;
  alu_op_t         dec_alu_op;
  mul_op_t         dec_mul_op;
  logic            dec_is_mul;
  logic [XLEN-1:0] dec_op_b;
  logic [TAG_W-1:0] next_tag;

  assign opcode = instruction[6:0];
  assign funct3 = instruction[14:12];
  assign funct7 = instruction[31:25];
  assign shamt  = instruction[24:20];

  always_comb begin
    dec_alu_op = ALU_ADD;  // Loads, stores and unknown opcodes just add
    dec_mul_op = MUL_LO;
    dec_is_mul = 1'b0;
    dec_op_b   = src_b;
    if (alu_control) begin
      dec_alu_op = ALU_BRANCH;
    end else if (opcode == OPC_OP && funct7 == FUNCT7_MULDIV) begin
      dec_is_mul = (funct3[2] == 1'b0);  // Divide half is not supported
      dec_mul_op = mul_op_t'(funct3[1:0]);
      dec_alu_op = ALU_ZERO;
    end else if (opcode == OPC_OP) begin
      unique case (funct3)
        3'b000: dec_alu_op = (funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
        3'b001: dec_alu_op = ALU_SLL;
        3'b010: dec_alu_op = ALU_SLT;
        3'b011: dec_alu_op = ALU_SLTU;
        3'b100: dec_alu_op = ALU_XOR;
        3'b101: dec_alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
        3'b110: dec_alu_op = ALU_OR;
        3'b111: dec_alu_op = ALU_AND;
        default: dec_alu_op = ALU_ZERO;
      endcase
    end else if (opcode == OPC_OP_IMM) begin
      unique case (funct3)
        3'b000: dec_alu_op = ALU_ADD;
        3'b010: dec_alu_op = ALU_SLT;
        3'b011: dec_alu_op = ALU_SLTU;
        3'b100: dec_alu_op = ALU_XOR;
        3'b110: dec_alu_op = ALU_OR;
        3'b111: dec_alu_op = ALU_AND;
        3'b001: dec_alu_op = (funct7 == FUNCT7_BASE) ? ALU_SLL : ALU_ZERO;
        3'b101: begin
          if (funct7 == FUNCT7_BASE) dec_alu_op = ALU_SRL;
          else if (funct7 == FUNCT7_ALT) dec_alu_op = ALU_SRA;
          else dec_alu_op = ALU_ZERO;  // Bad shift funct7
        end
        default: dec_alu_op = ALU_ZERO;
      endcase
      if (funct3 == 3'b001 || funct3 == 3'b101) begin
        dec_op_b = {{(XLEN-5){1'b0}}, shamt};  // Immediate shift amount
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_valid <= 1'b0;
      alu_valid   <= 1'b0;
      mul_valid   <= 1'b0;
      next_tag    <= '0;
    end else begin
      issue_valid <= in_valid;
      alu_valid   <= in_valid & ~dec_is_mul;
      mul_valid   <= in_valid & dec_is_mul;
      if (in_valid) next_tag <= next_tag + 1'b1;  // Wraps modulo QUEUE_DEPTH
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      alu_op     <= dec_alu_op;
      alu_funct3 <= funct3;
      mul_op     <= dec_mul_op;
      op_a       <= src_a;
      op_b       <= dec_op_b;
      issue_tag  <= next_tag;
    end
  end

endmodule

/* rtl/result_merge.sv */
`timescale 1ns/1ps

module result_merge (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     issue_valid,
  input  logic                     alu_done,
  input  logic [ex_pkg::TAG_W-1:0] alu_done_tag,
  input  logic [ex_pkg::XLEN-1:0]  alu_result,
  input  logic                     alu_branch_taken,
  input  logic                     mul_done,
  input  logic [ex_pkg::TAG_W-1:0] mul_done_tag,
  input  logic [ex_pkg::XLEN-1:0]  mul_result,
  input  logic                     out_credit,
  output logic                     out_valid,
  output logic [ex_pkg::XLEN-1:0]  out_result,
  output logic                     out_branch_taken,
  output logic                     in_credit
);
  import ex_pkg::*;

  slot_state_t       slot_state  [QUEUE_DEPTH];
  logic [XLEN-1:0]   slot_result [QUEUE_DEPTH];
  logic              slot_flag   [QUEUE_DEPTH];
  logic [TAG_W-1:0]  head_ptr;
  logic [TAG_W-1:0]  tail_ptr;
  logic [CREDIT_W-1:0] credit_cnt;
  logic              head_alu_hit;
  logic              head_mul_hit;
  logic              head_ready;
  logic              pop;
  logic [XLEN-1:0]   head_result;
  logic              head_flag;

  // A result arriving for the head slot goes straight out
  assign head_alu_hit = alu_done && (alu_done_tag == head_ptr);
  assign head_mul_hit = mul_done && (mul_done_tag == head_ptr);
  assign head_ready   = (slot_state[head_ptr] == SLOT_DONE) || head_alu_hit || head_mul_hit;
  assign pop          = head_ready && (credit_cnt != '0);

  always_comb begin
    if (slot_state[head_ptr] == SLOT_DONE) begin
      head_result = slot_result[head_ptr];
      head_flag   = slot_flag[head_ptr];
    end else if (head_alu_hit) begin
      head_result = alu_result;
      head_flag   = alu_branch_taken;
    end else begin
      head_result = mul_result;
      head_flag   = 1'b0;  // Multiplies never branch
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr   <= '0;
      tail_ptr   <= '0;
      credit_cnt <= CREDIT_W'(SINK_CREDITS);
      out_valid  <= 1'b0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
        slot_state[i] <= SLOT_FREE;
      end
    end else begin
      out_valid <= pop;
      if (issue_valid) begin
        slot_state[tail_ptr] <= SLOT_WAIT;
        tail_ptr             <= tail_ptr + 1'b1;
      end
      if (alu_done) slot_state[alu_done_tag] <= SLOT_DONE;
      if (mul_done) slot_state[mul_done_tag] <= SLOT_DONE;
      // Freeing comes last so a bypassed result does not linger
      if (pop) begin
        slot_state[head_ptr] <= SLOT_FREE;
        head_ptr             <= head_ptr + 1'b1;
      end
      unique case ({out_credit, pop})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (alu_done) begin
      slot_result[alu_done_tag] <= alu_result;
      slot_flag[alu_done_tag]   <= alu_branch_taken;
    end
    if (mul_done) begin
      slot_result[mul_done_tag] <= mul_result;
      slot_flag[mul_done_tag]   <= 1'b0;
    end
    if (pop) begin
      out_result       <= head_result;
      out_branch_taken <= head_flag;
    end
  end

  // Each result leaving frees one queue entry for upstream
  assign in_credit = out_valid;

endmodule

/* sim/ex_cases.txt */
# instruction src_a src_b alu_control expected_result expected_flag (all hex)
# R-type, OP-IMM and other opcodes, branches, then mixed multiply/ALU streams
002081B3 7FFFFFFF 00000001 0 80000000 0
402081B3 00000000 00000001 0 FFFFFFFF 0
0020F1B3 F0F0F0F0 FF00FF00 0 F000F000 0
0020C1B3 AAAAAAAA FFFFFFFF 0 55555555 0
002091B3 00000003 00000021 0 00000006 0
0020D1B3 80000000 0000001F 0 00000001 0
4020D1B3 F0000000 00000004 0 FF000000 0
0020A1B3 FFFFFFFF 00000001 0 00000001 0
0020B1B3 FFFFFFFF 00000001 0 00000000 0
00508193 0000000A 00000005 0 0000000F 0
FFF0A193 FFFFFFFE FFFFFFFF 0 00000001 0
FFF0C193 12345678 FFFFFFFF 0 EDCBA987 0
0FF0F193 12345678 000000FF 0 00000078 0
00409193 0000000F DEADBEEF 0 000000F0 0
0080D193 80000000 00000001 0 00800000 0
4080D193 80000000 00000001 0 FF800000 0
40409193 0000000F 00000001 0 00000000 0
0280D193 80000000 00000001 0 00000000 0
0040A183 00001000 00000004 0 00001004 0
0020A423 00002000 00000008 0 00002008 0
00208063 00000005 00000005 1 00000000 1
00209063 00000005 00000006 1 FFFFFFFF 1
0020C063 80000000 7FFFFFFF 1 00000001 1
0020C063 7FFFFFFF 80000000 1 FFFFFFFF 0
0020D063 00000000 FFFFFFFF 1 00000001 1
0020E063 80000000 7FFFFFFF 1 00000001 0
0020F063 80000000 7FFFFFFF 1 00000001 1
0020A063 00000009 00000003 1 00000006 0
002081B3 00000007 00000007 1 00000000 1
022081B3 FFFFFFFF 00000003 0 FFFFFFFD 0
022091B3 FFFFFFFF 00000003 0 FFFFFFFF 0
0220A1B3 FFFFFFFF FFFFFFFF 0 FFFFFFFF 0
0220B1B3 FFFFFFFF FFFFFFFF 0 FFFFFFFE 0
002081B3 00000001 00000002 0 00000003 0
022081B3 7FFFFFFF 7FFFFFFF 0 00000001 0
0020C063 FFFFFFFF 00000001 1 FFFFFFFE 1
022091B3 80000000 7FFFFFFF 0 C0000000 0
0220A1B3 80000000 80000000 0 C0000000 0
0220B1B3 00010000 00010000 0 00000001 0
0020E1B3 00000001 00000002 0 00000003 0
0220C1B3 00000064 00000005 0 00000000 0

/* sim/tb_ex_unit.sv */
`timescale 1ns/1ps

module tb_ex_unit;
  import ex_pkg::*;

  localparam int HOLD_CYCLES = 60;  // Sink withholds credits this long after reset

  logic            clk;
  logic            rst;
  logic            in_valid;
  logic [31:0]     instruction;
  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] src_b;
  logic            alu_control;
  logic            in_credit;
  logic            out_valid;
  logic [XLEN-1:0] out_result;
  logic            out_branch_taken;
  logic            out_credit;

  logic [31:0] case_instr[$];
  logic [31:0] case_a[$];
  logic [31:0] case_b[$];
  logic        case_ctrl[$];
  logic [31:0] case_result[$];
  logic        case_flag[$];
  int          expect_q[$];  // Case indexes in issue order
  int          num_cases;
  int          issued;
  int          delivered;
  int          in_credits_seen;
  int          credits_granted;
  int          credits_owed;
  int          drv_credits;
  int          cycle;
  int          value_errors;
  int          protocol_errors;
  int unsigned seed;

  ex_unit i_ex_unit (
    .clk(clk), .rst(rst), .in_valid(in_valid), .instruction(instruction),
    .src_a(src_a), .src_b(src_b), .alu_control(alu_control), .in_credit(in_credit),
    .out_valid(out_valid), .out_result(out_result),
    .out_branch_taken(out_branch_taken), .out_credit(out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic load_cases();
    int               fd;
    int               n;
    logic [8*160-1:0] skip_line;
    logic [31:0]      f_instr;
    logic [31:0]      f_a;
    logic [31:0]      f_b;
    logic [31:0]      f_ctrl;
    logic [31:0]      f_res;
    logic [31:0]      f_flag;
    fd = $fopen("sim/ex_cases.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%h %h %h %h %h %h", f_instr, f_a, f_b, f_ctrl, f_res, f_flag);
        if (n == 6) begin
          case_instr.push_back(f_instr);
          case_a.push_back(f_a);
          case_b.push_back(f_b);
          case_ctrl.push_back(f_ctrl[0]);
          case_result.push_back(f_res);
          case_flag.push_back(f_flag[0]);
        end else begin
          n = $fgets(skip_line, fd);  // Rest of a comment line
        end
      end
      $fclose(fd);
    end
    num_cases = case_instr.size();
  endtask

  task automatic check_outputs();
    int idx;
    if (in_credit) begin
      in_credits_seen++;
      drv_credits++;
      if (drv_credits > QUEUE_DEPTH) begin
        $display("More input credits came back than were spent, at %0t", $time);
        protocol_errors++;
      end
    end
    if (out_valid) begin
      delivered++;
      credits_owed++;
      if (delivered > SINK_CREDITS + credits_granted) begin
        $display("Result delivered without a downstream credit at %0t", $time);
        protocol_errors++;
      end
      if (expect_q.size() == 0) begin
        $display("Result appeared with no operation outstanding at %0t", $time);
        protocol_errors++;
      end else begin
        idx = expect_q.pop_front();
        if (out_result !== case_result[idx]) begin
          $display("[ERROR] %0t: case %0d result %h, expected %h",
                   $time, idx, out_result, case_result[idx]);
          value_errors++;
        end
        if (out_branch_taken !== case_flag[idx]) begin
          $display("[ERROR] %0t: case %0d branch flag %b, expected %b",
                   $time, idx, out_branch_taken, case_flag[idx]);
          value_errors++;
        end
      end
    end
  endtask

  task automatic drive_sink();
    out_credit = 1'b0;
    if (cycle >= HOLD_CYCLES && credits_owed > 0 && ($urandom % 3) == 0) begin
      out_credit = 1'b1;  // Hand back one consumed slot
      credits_owed--;
      credits_granted++;
    end
  endtask

  task automatic drive_input();
    in_valid = 1'b0;
    if (issued < num_cases && drv_credits > 0 && ($urandom % 4) != 0) begin
      in_valid    = 1'b1;
      instruction = case_instr[issued];
      src_a       = case_a[issued];
      src_b       = case_b[issued];
      alu_control = case_ctrl[issued];
      expect_q.push_back(issued);
      issued++;
      drv_credits--;
    end
  endtask

  task automatic print_counts();
    $display("Results checked: %0d of %0d, value errors: %0d, protocol errors: %0d",
             delivered, num_cases, value_errors, protocol_errors);
  endtask

  initial begin
    seed        = $urandom(92023);
    rst         = 1'b1;
    in_valid    = 1'b0;
    instruction = '0;
    src_a       = '0;
    src_b       = '0;
    alu_control = 1'b0;
    out_credit  = 1'b0;
    drv_credits = QUEUE_DEPTH;
    load_cases();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (num_cases == 0) begin
      $display("No cases could be read from sim/ex_cases.txt");
      $display("Testbench failed");
    end else begin
      while (delivered < num_cases) begin
        @(negedge clk);
        cycle++;
        check_outputs();
        drive_sink();
        drive_input();
      end
      repeat (20) begin  // Catch stray outputs after the drain
        @(negedge clk);
        check_outputs();
        drive_sink();
      end
      if (in_credits_seen != delivered) begin
        $display("Input credits returned (%0d) differ from results delivered (%0d)",
                 in_credits_seen, delivered);
        protocol_errors++;
      end
      if (drv_credits != QUEUE_DEPTH) begin
        $display("Driver holds %0d credits after the drain instead of %0d",
                 drv_credits, QUEUE_DEPTH);
        protocol_errors++;
      end
      print_counts();
      if (value_errors == 0 && protocol_errors == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
    end
    $finish;
  end

  initial begin
    wait (num_cases > 0);
    repeat (num_cases * 40 + 2000) @(posedge clk);
    $display("Run timed out waiting for results");
    print_counts();
    $display("Testbench failed");
    $finish;
  end

endmodule

/* verilog.f */
rtl/ex_pkg.sv
rtl/op_decode.sv
rtl/int_alu.sv
rtl/mul_pipe.sv
rtl/result_merge.sv
rtl/ex_unit.sv
sim/tb_ex_unit.sv
